//--- design/dataPathPkg.sv
package dataPathPkg;

	// Datapath word width.
	localparam int wordWidth = 32;

	// General registers R0 to R15.
	localparam int regCount = 16;

	// Shift amount taken from the low bits of the bus.
	localparam int shiftBits = 5;

	// ALU operations applied to Y and the bus.
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOr  = 4'd3,
		opShr = 4'd4, // Logical right.
		opShl = 4'd5,
		opRor = 4'd6,
		opRol = 4'd7,
		opMul = 4'd8, // Signed, full 64 bits.
		opDiv = 4'd9, // Quotient low, remainder high.
		opNeg = 4'd10,
		opNot = 4'd11
	} aluOpT;

endpackage

//--- design/busIf.sv
`timescale 1ns/100ps

interface busIf import dataPathPkg::*; ();

	logic [wordWidth-1:0] busData; // The shared bus.

	// Values each unit offers to the bus.
	logic [wordWidth-1:0] regData;
	logic [wordWidth-1:0] hiData;
	logic [wordWidth-1:0] loData;
	logic [2*wordWidth-1:0] zData;
	logic [wordWidth-1:0] mdrData;
	logic [wordWidth-1:0] pcData;

	modport busMux (
		output busData,
		input regData, hiData, loData, zData, mdrData, pcData
	);

	modport regFile (input busData, output regData, hiData, loData);
	modport alu (input busData, output zData);
	modport mem (input busData, output mdrData);
	modport instr (input busData, output pcData);

endinterface

//--- design/busMux.sv
`timescale 1ns/100ps

module busMux import dataPathPkg::*; (
	busIf.busMux bus,
	input logic pcOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic mdrOut,
	input logic hiOut,
	input logic loOut,
	input logic [regCount-1:0] regOut
);

	logic regSelected;

	// Register file already picked the lowest set regOut bit.
	assign regSelected = |regOut;

	always_comb begin
		if (mdrOut) begin
			bus.busData = bus.mdrData;
		end else if (pcOut) begin
			bus.busData = bus.pcData;
		end else if (zLowOut) begin
			bus.busData = bus.zData[wordWidth-1:0];
		end else if (zHighOut) begin
			bus.busData = bus.zData[2*wordWidth-1:wordWidth];
		end else if (hiOut) begin
			bus.busData = bus.hiData;
		end else if (loOut) begin
			bus.busData = bus.loData;
		end else if (regSelected) begin
			bus.busData = bus.regData;
		end else begin
			bus.busData = '0; // Idle bus.
		end
	end

endmodule

//--- design/registerFile.sv
`timescale 1ns/100ps

module registerFile import dataPathPkg::*; (
	input logic Clock,
	input logic arstN,
	busIf.regFile bus,
	input logic [regCount-1:0] regIn,
	input logic [regCount-1:0] regOut,
	input logic hiIn,
	input logic loIn
);

	logic [wordWidth-1:0] regs [regCount];
	logic [wordWidth-1:0] hiReg;
	logic [wordWidth-1:0] loReg;
	logic [wordWidth-1:0] selWord;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
			hiReg <= '0;
			loReg <= '0;
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (regIn[i]) begin
					regs[i] <= bus.busData;
				end
			end
			if (hiIn) begin
				hiReg <= bus.busData;
			end
			if (loIn) begin
				loReg <= bus.busData;
			end
		end
	end

	// Scan downward so the lowest set bit is the last one written.
	always_comb begin
		selWord = '0;
		for (int i = regCount - 1; i >= 0; i--) begin
			if (regOut[i]) begin
				selWord = regs[i];
			end
		end
	end

	assign bus.regData = selWord;
	assign bus.hiData = hiReg;
	assign bus.loData = loReg;

endmodule

//--- design/aluUnit.sv
`timescale 1ns/100ps

module aluUnit import dataPathPkg::*; (
	input logic Clock,
	input logic arstN,
	busIf.alu bus,
	input logic yIn,
	input logic zIn,
	input aluOpT aluOp
);

	logic [wordWidth-1:0] yReg;
	logic [2*wordWidth-1:0] zReg;

	logic [wordWidth-1:0] aVal;
	logic [wordWidth-1:0] bVal;
	logic [shiftBits-1:0] shAmt;
	logic [2*wordWidth-1:0] rorWide;
	logic [2*wordWidth-1:0] rolWide;
	logic signed [2*wordWidth-1:0] product;
	logic [wordWidth-1:0] quotient;
	logic [wordWidth-1:0] remainder;
	logic [2*wordWidth-1:0] result;

	assign aVal = yReg;
	assign bVal = bus.busData;
	assign shAmt = bVal[shiftBits-1:0];

	// Rotates come from shifting a doubled copy of A.
	assign rorWide = {aVal, aVal} >> shAmt;
	assign rolWide = {aVal, aVal} << shAmt;
	assign product = $signed(aVal) * $signed(bVal);

	always_comb begin
		if (bVal == '0) begin
			quotient = '1; // Divide by zero.
			remainder = aVal;
		end else begin
			quotient = $signed(aVal) / $signed(bVal);
			remainder = $signed(aVal) % $signed(bVal);
		end
	end

	always_comb begin
		result = '0;
		case (aluOp)
			opAdd: result[wordWidth-1:0] = aVal + bVal;
			opSub: result[wordWidth-1:0] = aVal - bVal;
			opAnd: result[wordWidth-1:0] = aVal & bVal;
			opOr: result[wordWidth-1:0] = aVal | bVal;
			opShr: result[wordWidth-1:0] = aVal >> shAmt;
			opShl: result[wordWidth-1:0] = aVal << shAmt;
			opRor: result[wordWidth-1:0] = rorWide[wordWidth-1:0];
			opRol: result[wordWidth-1:0] = rolWide[2*wordWidth-1:wordWidth];
			opMul: result = product;
			opDiv: result = {remainder, quotient};
			opNeg: result[wordWidth-1:0] = -bVal; // B only.
			opNot: result[wordWidth-1:0] = ~bVal;
			default: result = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			yReg <= '0;
			zReg <= '0;
		end else begin
			if (yIn) begin
				yReg <= bus.busData;
			end
			if (zIn) begin
				zReg <= result; // Both halves at once.
			end
		end
	end

	assign bus.zData = zReg;

endmodule

//--- design/memoryInterface.sv
`timescale 1ns/100ps

module memoryInterface import dataPathPkg::*; (
	input logic Clock,
	input logic arstN,
	busIf.mem bus,
	input logic marIn,
	input logic mdrIn,
	input logic read,
	input logic [wordWidth-1:0] mDataIn,
	output logic [wordWidth-1:0] marValue
);

	logic [wordWidth-1:0] marReg;
	logic [wordWidth-1:0] mdrReg;
	logic [wordWidth-1:0] mdrNext;

	// Memory side on a read, bus side otherwise.
	assign mdrNext = read ? mDataIn : bus.busData;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			marReg <= '0;
			mdrReg <= '0;
		end else begin
			if (marIn) begin
				marReg <= bus.busData;
			end
			if (mdrIn) begin
				mdrReg <= mdrNext;
			end
		end
	end

	assign marValue = marReg;
	assign bus.mdrData = mdrReg;

endmodule

//--- design/instrUnit.sv
`timescale 1ns/100ps

module instrUnit import dataPathPkg::*; (
	input logic Clock,
	input logic arstN,
	busIf.instr bus,
	input logic pcIn,
	input logic incPc,
	input logic irIn,
	output logic [wordWidth-1:0] irValue
);

	logic [wordWidth-1:0] pcReg;
	logic [wordWidth-1:0] irReg;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pcReg <= '0;
			irReg <= '0;
		end else begin
			if (pcIn) begin
				pcReg <= bus.busData; // Load beats increment.
			end else if (incPc) begin
				pcReg <= pcReg + 1'b1;
			end
			if (irIn) begin
				irReg <= bus.busData;
			end
		end
	end

	assign bus.pcData = pcReg;
	assign irValue = irReg;

endmodule

//--- design/dataPath.sv
`timescale 1ns/100ps

module dataPath import dataPathPkg::*; (
	input logic Clock,
	input logic arstN,
	input logic pcOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic mdrOut,
	input logic hiOut,
	input logic loOut,
	input logic [regCount-1:0] regOut,
	input logic [regCount-1:0] regIn,
	input logic hiIn,
	input logic loIn,
	input logic marIn,
	input logic pcIn,
	input logic mdrIn,
	input logic irIn,
	input logic yIn,
	input logic zIn,
	input logic incPc,
	input logic read,
	input aluOpT aluOp,
	input logic [wordWidth-1:0] mDataIn,
	output logic [wordWidth-1:0] busValue,
	output logic [wordWidth-1:0] marValue,
	output logic [wordWidth-1:0] irValue
);

	busIf bus ();

	busMux i_busMux (
		.bus(bus), .pcOut(pcOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
		.mdrOut(mdrOut), .hiOut(hiOut), .loOut(loOut), .regOut(regOut)
	);

	registerFile i_registerFile (
		.Clock(Clock), .arstN(arstN), .bus(bus),
		.regIn(regIn), .regOut(regOut), .hiIn(hiIn), .loIn(loIn)
	);

	aluUnit i_aluUnit (
		.Clock(Clock), .arstN(arstN), .bus(bus),
		.yIn(yIn), .zIn(zIn), .aluOp(aluOp)
	);

	memoryInterface i_memoryInterface (
		.Clock(Clock), .arstN(arstN), .bus(bus),
		.marIn(marIn), .mdrIn(mdrIn), .read(read), .mDataIn(mDataIn),
		.marValue(marValue)
	);

	instrUnit i_instrUnit (
		.Clock(Clock), .arstN(arstN), .bus(bus),
		.pcIn(pcIn), .incPc(incPc), .irIn(irIn), .irValue(irValue)
	);

	// Bus made visible for observing every transfer.
	assign busValue = bus.busData;

endmodule

//--- verif/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic Clock,
	output logic arstN
);

	initial begin
		Clock = 1'b0;
		forever begin
			#5 Clock = ~Clock;
		end
	end

	// Held for eight rising edges, released on a falling edge.
	initial begin
		arstN = 1'b0;
		repeat (8) @(posedge Clock);
		@(negedge Clock);
		arstN = 1'b1;
	end

endmodule

//--- verif/dataPathTb.sv
`timescale 1ns/100ps

module dataPathTb import dataPathPkg::*; ();

	logic Clock;
	logic arstN;
	logic pcOut, zHighOut, zLowOut, mdrOut, hiOut, loOut;
	logic [regCount-1:0] regOut;
	logic [regCount-1:0] regIn;
	logic hiIn, loIn, marIn, pcIn, mdrIn, irIn, yIn, zIn;
	logic incPc;
	logic read;
	aluOpT aluOp;
	logic [wordWidth-1:0] mDataIn;
	logic [wordWidth-1:0] busValue;
	logic [wordWidth-1:0] marValue;
	logic [wordWidth-1:0] irValue;

	int seed;
	int errorCount;
	int checkCount;
	int edgeCount = 0;
	bit timedOut = 1'b0;
	logic [wordWidth-1:0] busSample;

	clockGen i_clockGen (.Clock(Clock), .arstN(arstN));

	dataPath i_dataPath (
		.Clock(Clock), .arstN(arstN),
		.pcOut(pcOut), .zHighOut(zHighOut), .zLowOut(zLowOut), .mdrOut(mdrOut),
		.hiOut(hiOut), .loOut(loOut), .regOut(regOut), .regIn(regIn),
		.hiIn(hiIn), .loIn(loIn), .marIn(marIn), .pcIn(pcIn), .mdrIn(mdrIn),
		.irIn(irIn), .yIn(yIn), .zIn(zIn), .incPc(incPc), .read(read),
		.aluOp(aluOp), .mDataIn(mDataIn),
		.busValue(busValue), .marValue(marValue), .irValue(irValue)
	);

	always @(posedge Clock) edgeCount <= edgeCount + 1;

	initial begin
		wait (timedOut);
		$display("Timeout: no clock edge arrived in time");
		$display("Simulation FAILED");
		$finish;
	end

	task automatic checkValue(input string name, input logic [wordWidth-1:0] expected,
			input logic [wordWidth-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %s expected %h got %h", name, expected, actual);
		end
	endtask

	// Polls at odd offsets from the edges, returns 1 ns after the next one.
	task automatic waitEdge();
		int startCount;
		int guard;
		startCount = edgeCount;
		guard = 0;
		while (edgeCount == startCount) begin
			#2;
			guard++;
			if (guard > 20) begin
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic clearStrobes();
		{pcOut, zHighOut, zLowOut, mdrOut, hiOut, loOut} = '0;
		regOut = '0;
		regIn = '0;
		{hiIn, loIn, marIn, pcIn, mdrIn, irIn, yIn, zIn} = '0;
		incPc = 1'b0;
		read = 1'b0;
		aluOp = opAdd;
		mDataIn = '0;
	endtask

	// Bus sampled mid-cycle, then the edge commits the loads.
	task automatic runCycle();
		#4;
		busSample = busValue;
		waitEdge();
		clearStrobes();
	endtask

	task automatic loadMdr(input logic [wordWidth-1:0] word);
		mDataIn = word;
		read = 1'b1;
		mdrIn = 1'b1;
		runCycle();
	endtask

	task automatic loadReg(input int idx, input logic [wordWidth-1:0] word);
		loadMdr(word);
		mdrOut = 1'b1;
		regIn[idx] = 1'b1;
		runCycle();
	endtask

	task automatic readReg(input int idx, output logic [wordWidth-1:0] word);
		regOut[idx] = 1'b1;
		runCycle();
		word = busSample;
	endtask

	function automatic logic [2*wordWidth-1:0] aluModel(input aluOpT op,
			input logic [wordWidth-1:0] a, input logic [wordWidth-1:0] b);
		int sa;
		int sb;
		int s;
		longint prod;
		logic [wordWidth-1:0] lo;
		logic [wordWidth-1:0] hi;
		sa = a;
		sb = b;
		s = b[shiftBits-1:0];
		lo = '0;
		hi = '0;
		case (op)
			opAdd: lo = a + b;
			opSub: lo = a - b;
			opAnd: lo = a & b;
			opOr: lo = a | b;
			opShr: lo = a >> s;
			opShl: lo = a << s;
			opRor: lo = (a >> s) | (a << (32 - s));
			opRol: lo = (a << s) | (a >> (32 - s));
			opMul: begin
				prod = longint'(sa) * longint'(sb);
				{hi, lo} = prod;
			end
			opDiv: begin
				if (sb == 0) begin
					lo = '1;
					hi = a;
				end else begin
					lo = sa / sb;
					hi = sa % sb;
				end
			end
			opNeg: lo = 32'd0 - b;
			opNot: lo = ~b;
			default: lo = '0;
		endcase
		return {hi, lo};
	endfunction

	task automatic testReset();
		string name;
		runCycle();
		checkValue("busValue idle", '0, busSample);
		checkValue("marValue", '0, marValue);
		checkValue("irValue", '0, irValue);
		for (int i = 0; i < 6; i++) begin
			case (i)
				0: begin
					pcOut = 1'b1;
					name = "busValue pcOut";
				end
				1: begin
					mdrOut = 1'b1;
					name = "busValue mdrOut";
				end
				2: begin
					zLowOut = 1'b1;
					name = "busValue zLowOut";
				end
				3: begin
					zHighOut = 1'b1;
					name = "busValue zHighOut";
				end
				4: begin
					hiOut = 1'b1;
					name = "busValue hiOut";
				end
				default: begin
					loOut = 1'b1;
					name = "busValue loOut";
				end
			endcase
			runCycle();
			checkValue(name, '0, busSample);
		end
	endtask

	task automatic testRegisters();
		logic [wordWidth-1:0] words [regCount+2];
		logic [wordWidth-1:0] got;
		for (int i = 0; i < regCount + 2; i++) begin
			words[i] = $random(seed);
		end
		for (int i = 0; i < regCount; i++) begin
			loadReg(i, words[i]);
		end
		loadMdr(words[regCount]);
		mdrOut = 1'b1;
		hiIn = 1'b1;
		runCycle();
		loadMdr(words[regCount+1]);
		mdrOut = 1'b1;
		loIn = 1'b1;
		runCycle();
		for (int i = 0; i < regCount; i++) begin
			readReg(i, got);
			checkValue($sformatf("busValue R%0d", i), words[i], got);
		end
		hiOut = 1'b1;
		runCycle();
		checkValue("busValue HI", words[regCount], busSample);
		loOut = 1'b1;
		runCycle();
		checkValue("busValue LO", words[regCount+1], busSample);
	endtask

	task automatic testAndSequence();
		logic [wordWidth-1:0] got;
		loadReg(4, 32'h12);
		loadReg(3, 32'h14);
		loadReg(7, 32'h18);
		pcOut = 1'b1; // Fetch.
		marIn = 1'b1;
		incPc = 1'b1;
		runCycle();
		checkValue("marValue", 32'h0, marValue);
		pcOut = 1'b1;
		runCycle();
		checkValue("busValue PC", 32'h1, busSample);
		loadMdr(32'h2A1B8000);
		mdrOut = 1'b1;
		irIn = 1'b1;
		runCycle();
		checkValue("irValue", 32'h2A1B8000, irValue);
		regOut[4] = 1'b1;
		yIn = 1'b1;
		runCycle();
		regOut[3] = 1'b1;
		aluOp = opAnd;
		zIn = 1'b1;
		runCycle();
		zLowOut = 1'b1;
		regIn[7] = 1'b1;
		runCycle();
		readReg(7, got);
		checkValue("busValue R7", 32'h10, got);
	endtask

	task automatic aluCase(input aluOpT op, input logic [wordWidth-1:0] a,
			input logic [wordWidth-1:0] b);
		logic [2*wordWidth-1:0] expected;
		expected = aluModel(op, a, b);
		loadReg(1, a);
		loadReg(2, b);
		regOut[1] = 1'b1;
		yIn = 1'b1;
		runCycle();
		regOut[2] = 1'b1; // B comes from R2.
		aluOp = op;
		zIn = 1'b1;
		runCycle();
		zLowOut = 1'b1;
		runCycle();
		checkValue($sformatf("zLow %s", op.name()), expected[wordWidth-1:0], busSample);
		zHighOut = 1'b1;
		runCycle();
		checkValue($sformatf("zHigh %s", op.name()), expected[2*wordWidth-1:wordWidth],
			busSample);
	endtask

	task automatic testAlu();
		aluOpT op;
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		for (int k = 0; k < 12; k++) begin
			op = aluOpT'(k);
			for (int n = 0; n < 3; n++) begin
				a = $random(seed);
				b = $random(seed);
				aluCase(op, a, b);
			end
			a = $random(seed);
			if (op == opDiv) begin
				aluCase(op, a, '0);
			end
			if (op inside {opShr, opShl, opRor, opRol}) begin
				b = $random(seed);
				aluCase(op, a, b & ~32'h1F); // Upper bits must be ignored.
				aluCase(op, a, (b & ~32'h1F) | 32'd31);
			end
		end
	endtask

	task automatic testPriority();
		logic [wordWidth-1:0] words [4];
		for (int i = 0; i < 4; i++) begin
			words[i] = $random(seed);
		end
		loadReg(5, words[0]);
		loadReg(2, words[1]);
		loadReg(6, words[2]);
		loadReg(8, words[3]);
		regOut[5] = 1'b1;
		marIn = 1'b1; // MAR from a register.
		runCycle();
		checkValue("marValue from R5", words[0], marValue);
		loadMdr(~words[0]);
		mdrOut = 1'b1;
		regOut[5] = 1'b1;
		runCycle();
		checkValue("busValue mdr over reg", ~words[0], busSample);
		regOut[2] = 1'b1;
		regOut[5] = 1'b1;
		runCycle();
		checkValue("busValue R2 over R5", words[1], busSample);
		regOut[6] = 1'b1;
		pcIn = 1'b1;
		incPc = 1'b1;
		runCycle();
		pcOut = 1'b1;
		runCycle();
		checkValue("busValue PC load", words[2], busSample);
		regOut[8] = 1'b1;
		mdrIn = 1'b1; // No read, so MDR takes the bus.
		runCycle();
		mdrOut = 1'b1;
		runCycle();
		checkValue("busValue MDR from bus", words[3], busSample);
	endtask

	initial begin
		int resetGuard;
		seed = 7991;
		errorCount = 0;
		checkCount = 0;
		busSample = '0;
		clearStrobes();
		waitEdge();
		resetGuard = 0;
		while (!arstN) begin
			waitEdge();
			resetGuard++;
			if (resetGuard > 30) begin
				timedOut = 1'b1;
			end
		end

		testReset();
		testRegisters();
		testAndSequence();
		testAlu();
		testPriority();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
design/dataPathPkg.sv
design/busIf.sv
design/busMux.sv
design/registerFile.sv
design/aluUnit.sv
design/memoryInterface.sv
design/instrUnit.sv
design/dataPath.sv
verif/clockGen.sv
verif/dataPathTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module dataPathTb -f files.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "Run result: pass"
else
	echo "Run result: fail"
	exit 1
fi
